/* files.f */
+incdir+hdl
hdl/mig_pkg.sv
hdl/sync_fifo.sv
hdl/ddr_model_engine.sv
hdl/mig_wrapper.sv
tb/tb_mig_wrapper.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mig_wrapper testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mig_wrapper \
    -f files.f -o sim_mig_wrapper
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_mig_wrapper)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1

/* tb/tb_mig_wrapper.sv */
`timescale 1ns/1ps
`include "mig_defs.svh"

module tb_mig_wrapper
    import mig_pkg::*;
();

    // Six tests of up to about 200 cycles plus calibration, with margin
    localparam int WATCHDOG_NS = 20000;
    localparam int WAIT_LIMIT  = 400;

    logic                    clk_mif = 1'b0;
    logic                    rst_n;
    logic                    cmd_en;
    mig_instr_t              cmd_instr;
    logic [5:0]              cmd_bl;
    logic [29:0]             cmd_byte_addr;
    logic                    cmd_empty;
    logic                    cmd_full;
    logic                    wr_en;
    logic [15:0]             wr_mask;
    logic [127:0]            wr_data;
    logic                    wr_empty;
    logic                    wr_full;
    logic [`MIG_COUNT_W-1:0] wr_count;
    logic                    wr_underrun;
    logic                    rd_en = 1'b0;
    logic [127:0]            rd_data;
    logic                    rd_full;
    logic                    rd_empty;
    logic                    rd_overflow;
    logic [`MIG_COUNT_W-1:0] rd_count;
    logic                    calib_done;
    logic                    error;

    integer       seed;
    int           errors;
    int           rd_errors;
    int           errors_seen;
    logic         drain = 1'b0;
    logic [127:0] exp_w;
    logic [127:0] shadow [`MIG_MEM_WORDS];
    logic [127:0] wbuf [64];
    logic [15:0]  mbuf [64];
    logic [127:0] exp_q [$];

    mig_wrapper UUT (.*);

    always #5 clk_mif = ~clk_mif;

    // Expected memory word after a masked write, mask bit 1 keeps the old byte
    function automatic logic [127:0] merge_bytes(input logic [127:0] old_word,
                                                 input logic [127:0] new_word,
                                                 input logic [15:0]  mask);
        logic [127:0] result;
        result = old_word;
        for (int b = 0; b < 16; b++) begin
            if (!mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [127:0] rand_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic fill_words(input int n);
        for (int i = 0; i < n; i++) begin
            wbuf[i] = rand_word();
            mbuf[i] = '0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_mif);
        rst_n <= 1'b0;
        repeat (10) @(posedge clk_mif);
        rst_n <= 1'b1;
        @(negedge clk_mif);
    endtask

    task automatic push_cmd(input mig_instr_t instr, input int waddr, input int n);
        @(posedge clk_mif);
        cmd_en        <= 1'b1;
        cmd_instr     <= instr;
        cmd_bl        <= 6'(n - 1);
        cmd_byte_addr <= 30'(waddr * 16);
        @(posedge clk_mif);
        cmd_en <= 1'b0;
    endtask

    // Only the first supply words reach the write FIFO
    task automatic write_burst(input int waddr, input int n, input int supply);
        int a;
        for (int i = 0; i < supply; i++) begin
            a = (waddr + i) % `MIG_MEM_WORDS;
            @(posedge clk_mif);
            wr_en   <= 1'b1;
            wr_data <= wbuf[i];
            wr_mask <= mbuf[i];
            @(posedge clk_mif);
            wr_en <= 1'b0;
            shadow[a] = merge_bytes(shadow[a], wbuf[i], mbuf[i]);
        end
        push_cmd(MIG_WR, waddr, n);
    endtask

    task automatic read_burst(input int waddr, input int n, input int nexp);
        for (int i = 0; i < nexp; i++) begin
            exp_q.push_back(shadow[(waddr + i) % `MIG_MEM_WORDS]);
        end
        push_cmd(MIG_RD, waddr, n);
    endtask

    task automatic check_val(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_queues_empty();
        int n;
        n = 0;
        while (!(cmd_empty && wr_empty) && n < WAIT_LIMIT) begin
            @(negedge clk_mif);
            n++;
        end
        assert (n < WAIT_LIMIT) else begin
            $display("Command and write FIFOs did not drain in time");
            errors++;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || !rd_empty || !cmd_empty) && n < WAIT_LIMIT) begin
            @(negedge clk_mif);
            n++;
        end
        assert (n < WAIT_LIMIT) else begin
            $display("Read data timed out with %0d words still missing", exp_q.size());
            errors++;
        end
        exp_q.delete();
    endtask

    task automatic count_pulses(input logic underrun, input int want);
        int seen;
        int n;
        seen = 0;
        n = 0;
        while (seen < want && n < WAIT_LIMIT) begin
            @(negedge clk_mif);
            n++;
            if (underrun ? wr_underrun : rd_overflow) begin
                seen++;
            end
        end
        assert (seen == want) else begin
            $display("Saw %0d of %0d expected %s pulses", seen, want,
                     underrun ? "wr_underrun" : "rd_overflow");
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %0s: %0s", name, (errors + rd_errors == errors_seen) ? "pass" : "FAIL");
        errors_seen = errors + rd_errors;
    endtask

    // Checker pops the head word on every edge while draining
    always @(posedge clk_mif) begin
        if (rd_en && !rd_empty) begin
            if (exp_q.size() == 0) begin
                $display("Read FIFO returned a word no read command asked for at %0t", $time);
                rd_errors++;
            end else begin
                exp_w = exp_q.pop_front();
                assert (rd_data == exp_w) else begin
                    $display("ERR %0t rd_data expected %h actual %h", $time, exp_w, rd_data);
                    rd_errors++;
                end
            end
        end
        rd_en <= drain && rst_n;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before the tests completed", $time);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int edges;
        int n;
        int prev;
        seed          = 32'h8695_8582;
        rst_n         = 1'b0;
        cmd_en        = 1'b0;
        cmd_instr     = MIG_WR;
        cmd_bl        = '0;
        cmd_byte_addr = '0;
        wr_en         = 1'b0;
        wr_mask       = '0;
        wr_data       = '0;
        errors        = 0;
        rd_errors     = 0;
        errors_seen   = 0;

        apply_reset();
        check_val("cmd_empty", int'(cmd_empty), 1);
        check_val("wr_empty", int'(wr_empty), 1);
        check_val("rd_empty", int'(rd_empty), 1);
        check_val("wr_count", int'(wr_count), 0);
        check_val("rd_count", int'(rd_count), 0);
        check_val("error", int'(error), 0);
        check_val("calib_done", int'(calib_done), 0);
        // Count edges after the first edge with rst_n high
        @(posedge clk_mif);
        edges = 0;
        @(negedge clk_mif);
        while (!calib_done && edges < WAIT_LIMIT) begin
            @(posedge clk_mif);
            edges++;
            @(negedge clk_mif);
        end
        check_val("calib_done edges", edges, `MIG_CALIB_CYCLES);
        end_test("1 reset and calibration");

        apply_reset();
        fill_words(2);
        write_burst(100, 2, 2);
        fill_words(3);
        write_burst(102, 3, 3);
        fill_words(4);
        write_burst(105, 4, 4);
        fill_words(1);
        write_burst(109, 1, 1);
        @(negedge clk_mif);
        check_val("cmd_full", int'(cmd_full), 1);
        // Had this write been accepted it would underrun and raise error
        push_cmd(MIG_WR, 120, 1);
        @(negedge clk_mif);
        check_val("wr_count", int'(wr_count), 10);
        check_val("calib_done", int'(calib_done), 0);
        wait_queues_empty();
        drain = 1'b1;
        read_burst(100, 10, 10);
        wait_drained();
        check_val("error", int'(error), 0);
        end_test("2 queueing before calibration");

        drain = 1'b0;
        fill_words(16);
        write_burst(32, 16, 16);
        read_burst(32, 16, 16);
        // Wait until rd_count has risen and then holds for a cycle
        n = 0;
        prev = -1;
        while ((int'(rd_count) == 0 || int'(rd_count) != prev) && n < WAIT_LIMIT) begin
            prev = int'(rd_count);
            @(negedge clk_mif);
            n++;
        end
        check_val("rd_count", int'(rd_count), 16);
        check_val("error", int'(error), 0);
        drain = 1'b1;
        wait_drained();
        end_test("3 write then read");

        fill_words(1);
        write_burst(200, 1, 1);
        fill_words(1);
        mbuf[0] = 16'($random(seed));
        write_burst(200, 1, 1);
        read_burst(200, 1, 1);
        wait_drained();
        end_test("4 byte masks");

        drain = 1'b0;
        fill_words(64);
        write_burst(0, 64, 64);
        @(negedge clk_mif);
        check_val("wr_full", int'(wr_full), 1);
        read_burst(0, 64, 64);
        read_burst(64, 8, 0);
        count_pulses(1'b0, 8);
        check_val("error", int'(error), 1);
        check_val("rd_count", int'(rd_count), 64);
        check_val("rd_full", int'(rd_full), 1);
        drain = 1'b1;
        wait_drained();
        end_test("5 read overflow");

        drain = 1'b0;
        apply_reset();
        check_val("error", int'(error), 0);
        fill_words(2);
        write_burst(8, 4, 2);
        count_pulses(1'b1, 2);
        check_val("error", int'(error), 1);
        drain = 1'b1;
        read_burst(8, 4, 4);
        wait_drained();
        end_test("6 write underrun");

        $display("Tests run: 6, errors: %0d", errors + rd_errors);
        if (errors + rd_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* hdl/mig_wrapper.sv */
`timescale 1ns/1ps
`include "mig_defs.svh"

module mig_wrapper
    import mig_pkg::*;
(
    input  logic                    clk_mif,
    input  logic                    rst_n,
    // Command port
    input  logic                    cmd_en,
    input  mig_instr_t              cmd_instr,
    input  logic [5:0]              cmd_bl,
    input  logic [29:0]             cmd_byte_addr,
    output logic                    cmd_empty,
    output logic                    cmd_full,
    // Write data port
    input  logic                    wr_en,
    input  logic [15:0]             wr_mask,
    input  logic [127:0]            wr_data,
    output logic                    wr_empty,
    output logic                    wr_full,
    output logic [`MIG_COUNT_W-1:0] wr_count,
    output logic                    wr_underrun,
    // Read data port
    input  logic                    rd_en,
    output logic [127:0]            rd_data,
    output logic                    rd_full,
    output logic                    rd_empty,
    output logic                    rd_overflow,
    output logic [`MIG_COUNT_W-1:0] rd_count,
    // Status
    output logic                    calib_done,
    output logic                    error
);

    mig_cmd_t     cmd_in;
    mig_cmd_t     cmd_head;
    mig_wr_word_t wr_in;
    mig_wr_word_t wr_head;
    logic         cmd_pop;
    logic         wr_pop;
    logic         rd_push;
    logic [127:0] rd_word;

    assign cmd_in = '{instr: cmd_instr, bl: cmd_bl, byte_addr: cmd_byte_addr};
    assign wr_in  = '{mask: wr_mask, data: wr_data};

    sync_fifo #(
        .payload_t (mig_cmd_t),
        .DEPTH     (`MIG_CMD_DEPTH)
    ) cmd_fifo (
        .clk_mif   (clk_mif),
        .rst_n     (rst_n),
        .push      (cmd_en),
        .push_data (cmd_in),
        .pop       (cmd_pop),
        .pop_data  (cmd_head),
        .full      (cmd_full),
        .empty     (cmd_empty),
        .count     ()
    );

    sync_fifo #(
        .payload_t (mig_wr_word_t),
        .DEPTH     (`MIG_DATA_DEPTH)
    ) wr_fifo (
        .clk_mif   (clk_mif),
        .rst_n     (rst_n),
        .push      (wr_en),
        .push_data (wr_in),
        .pop       (wr_pop),
        .pop_data  (wr_head),
        .full      (wr_full),
        .empty     (wr_empty),
        .count     (wr_count)
    );

    sync_fifo #(
        .payload_t (logic [127:0]),
        .DEPTH     (`MIG_DATA_DEPTH)
    ) rd_fifo (
        .clk_mif   (clk_mif),
        .rst_n     (rst_n),
        .push      (rd_push),
        .push_data (rd_word),
        .pop       (rd_en),
        .pop_data  (rd_data),
        .full      (rd_full),
        .empty     (rd_empty),
        .count     (rd_count)
    );

    ddr_model_engine engine (
        .clk_mif     (clk_mif),
        .rst_n       (rst_n),
        .cmd_valid   (!cmd_empty),
        .cmd         (cmd_head),
        .cmd_pop     (cmd_pop),
        .wr_avail    (!wr_empty),
        .wr_word     (wr_head),
        .wr_pop      (wr_pop),
        .rd_full     (rd_full),
        .rd_push     (rd_push),
        .rd_word     (rd_word),
        .calib_done  (calib_done),
        .wr_underrun (wr_underrun),
        .rd_overflow (rd_overflow),
        .error       (error)
    );

endmodule

/* hdl/ddr_model_engine.sv */
`timescale 1ns/1ps
`include "mig_defs.svh"

module ddr_model_engine
    import mig_pkg::*;
(
    input  logic         clk_mif,
    input  logic         rst_n,
    // Command FIFO side
    input  logic         cmd_valid,
    input  mig_cmd_t     cmd,
    output logic         cmd_pop,
    // Write FIFO side
    input  logic         wr_avail,
    input  mig_wr_word_t wr_word,
    output logic         wr_pop,
    // Read FIFO side
    input  logic         rd_full,
    output logic         rd_push,
    output logic [127:0] rd_word,
    // Status
    output logic         calib_done,
    output logic         wr_underrun,
    output logic         rd_overflow,
    output logic         error
);

    localparam int ADDR_W  = $clog2(`MIG_MEM_WORDS);
    localparam int CALIB_W = $clog2(`MIG_CALIB_CYCLES + 1);
    localparam logic [CALIB_W-1:0] CALIB_LAST = CALIB_W'(`MIG_CALIB_CYCLES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } state_t;

    logic [127:0] mem [`MIG_MEM_WORDS];

    state_t             state;
    logic [ADDR_W-1:0]  addr;
    logic [5:0]         beats_left;
    logic [CALIB_W-1:0] calib_cnt;

    // Stand-in for memory calibration, a fixed wait after reset
    always_ff @(posedge clk_mif) begin
        if (!rst_n) begin
            calib_cnt  <= '0;
            calib_done <= 1'b0;
        end else if (!calib_done) begin
            calib_cnt <= calib_cnt + 1'b1;
            // Rises on the edge CALIB_CYCLES after the first one out of reset
            if (calib_cnt == CALIB_LAST) begin
                calib_done <= 1'b1;
            end
        end
    end

    // Take a command only from idle once calibrated
    assign cmd_pop = (state == ST_IDLE) && calib_done && cmd_valid;

    // One beat per cycle in either burst state
    assign wr_pop      = (state == ST_WRITE) && wr_avail;
    assign wr_underrun = (state == ST_WRITE) && !wr_avail;
    assign rd_push     = (state == ST_READ) && !rd_full;
    assign rd_overflow = (state == ST_READ) && rd_full;

    assign rd_word = mem[addr];

    always_ff @(posedge clk_mif) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            addr       <= '0;
            beats_left <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_pop) begin
                        // Word index is the byte address over 16, wrapped to the array
                        addr       <= cmd.byte_addr[ADDR_W+3:4];
                        beats_left <= cmd.bl;
                        case (cmd.instr)
                            MIG_WR:  state <= ST_WRITE;
                            MIG_RD:  state <= ST_READ;
                            default: state <= ST_IDLE;
                        endcase
                    end
                end
                ST_WRITE, ST_READ: begin
                    addr <= addr + 1'b1;
                    if (beats_left == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        beats_left <= beats_left - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Masked write, bytes with mask bit 0 are replaced
    always_ff @(posedge clk_mif) begin
        if (wr_pop) begin
            for (int i = 0; i < 16; i++) begin
                if (!wr_word.mask[i]) begin
                    mem[addr][8*i +: 8] <= wr_word.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_mif) begin
        if (!rst_n) begin
            error <= 1'b0;
        end else if (wr_underrun || rd_overflow) begin
            error <= 1'b1;
        end
    end

    a_cmd_pop_idle: assert property (@(posedge clk_mif) disable iff (!rst_n)
        cmd_pop |-> (state == ST_IDLE) && calib_done);

    a_pop_not_underrun: assert property (@(posedge clk_mif) disable iff (!rst_n)
        !(wr_pop && wr_underrun));

endmodule

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps
`include "mig_defs.svh"

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                    clk_mif,
    input  logic                    rst_n,
    input  logic                    push,
    input  payload_t                push_data,
    input  logic                    pop,
    output payload_t                pop_data,
    output logic                    full,
    output logic                    empty,
    output logic [`MIG_COUNT_W-1:0] count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [`MIG_COUNT_W-1:0] DEPTH_C = `MIG_COUNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Overflowing pushes and underflowing pops are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == DEPTH_C);
    assign empty = (count == '0);

    // First-word-fall-through: head entry is always on the output
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk_mif) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_mif) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count as is
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk_mif) disable iff (!rst_n)
        count <= DEPTH_C);

    a_full_empty_excl: assert property (@(posedge clk_mif) disable iff (!rst_n)
        !(full && empty));

endmodule

/* hdl/mig_pkg.sv */
package mig_pkg;

    // Command codes on cmd_instr
    // Any other code is popped and ignored
    typedef enum logic [2:0] {
        MIG_WR = 3'd0,
        MIG_RD = 3'd1
    } mig_instr_t;

    // One queued command
    // bl is burst length minus one, byte_addr[3:0] is ignored
    typedef struct packed {
        mig_instr_t  instr;
        logic [5:0]  bl;
        logic [29:0] byte_addr;
    } mig_cmd_t;

    // One write FIFO entry
    // A mask bit of 1 keeps the old byte
    typedef struct packed {
        logic [15:0]  mask;
        logic [127:0] data;
    } mig_wr_word_t;

endpackage

/* hdl/mig_defs.svh */
`ifndef MIG_DEFS_SVH
`define MIG_DEFS_SVH

// Command FIFO holds a few queued bursts
`define MIG_CMD_DEPTH 4

// Each data FIFO holds one full 64-word burst
`define MIG_DATA_DEPTH 64

// Width of wr_count and rd_count, as on the controller user port
`define MIG_COUNT_W 7

// Size of the behavioral memory in 128-bit words
`define MIG_MEM_WORDS 256

// Clock edges from reset release to calib_done
`define MIG_CALIB_CYCLES 64

`endif
